// ==== verilog.f ====
+incdir+source
source/videoPkg.sv
source/videoTiming.sv
source/layerRenderer.sv
source/romArbiter.sv
source/colorMixer.sv
source/videoTop.sv
bench/clockGen.sv
bench/videoTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f verilog.f --top-module videoTb -Mdir obj_dir -o videoSim &&
    ./obj_dir/videoSim ||
    { echo "simulation returned an error status"; exit 1; }

// ==== bench/videoTb.sv ====
`timescale 1ns/100ps
`include "video_consts.svh"

module videoTb;

    localparam int     runLines = 1 + 2 * `VID_LINES;             // line 261 plus two frames
    localparam longint runNs    = longint'(runLines) * 512 * 4 * 10;  // cen every 4 clocks
    localparam longint limitNs  = runNs + runNs / 10;            // ten percent margin
    localparam int     visPixels = 384 * 224;

    logic               clk;
    logic               rst;
    logic               cen;
    logic               romAck;
    videoPkg::romWord_t romData;
    videoPkg::hPos_t    hdump;
    videoPkg::vPos_t    vdump;
    logic               HS;
    logic               VS;
    logic               HB;
    logic               VB;
    videoPkg::pixel_t   pixel;
    logic               romReq;
    videoPkg::romAddr_t romAddr;

    // expected raster, stepped on every cen tick
    videoPkg::hPos_t    expH;
    videoPkg::vPos_t    expV;
    logic               expHS;
    logic               expVS;
    logic               expHB;
    logic               expVB;
    logic               expPreVB;
    videoPkg::pixel_t   expPix;
    int                 frameCount = 0;  // vdump wraps seen
    int                 ticks = 0;
    int                 visibleCount = 0;
    int                 clearCount = 0;  // visible pixels with every layer transparent
    int                 layerHits [`VID_LAYERS] = '{default: 0};
    int                 seedDummy;

    clockGen clkGen (
        .clk (clk),
        .rst (rst)
    );

    videoTop dut (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .HS      (HS),
        .VS      (VS),
        .HB      (HB),
        .VB      (VB),
        .pixel   (pixel),
        .romReq  (romReq),
        .romAddr (romAddr),
        .romAck  (romAck),
        .romData (romData)
    );

    // graphics ROM contents, hashed from the whole address
    function automatic videoPkg::romWord_t romWord(videoPkg::romAddr_t addr);
        logic [31:0] x;
        logic [7:0]  mask;
        logic [15:0] twice;
        int          k;
        x = {addr, ~addr} * 32'h9e3779b1;
        x = x ^ (x >> 15);
        x = x * 32'h85ebca6b;
        x = x ^ (x >> 13);
        case (addr[15:14])
            2'd0:    mask = 8'h11;  // top layer mostly opaque
            2'd1:    mask = 8'h5a;
            default: mask = 8'hb7;  // bottom layer full of holes
        endcase
        twice = {mask, mask} >> addr[2:0];  // holes move with the column
        mask  = twice[7:0];
        for (k = 0; k < 8; k++) begin
            if (mask[k]) begin
                x[4*k +: 4] = 4'h0;
            end
        end
        return x;
    endfunction

    // first opaque layer from the top, zero if none
    function automatic videoPkg::pixel_t refPixel(videoPkg::hPos_t h, videoPkg::vPos_t v);
        videoPkg::hPos_t     off;
        videoPkg::romWord_t  w;
        videoPkg::colorIdx_t c;
        int                  layer;
        off = h - `VID_HB_LEFT;
        if (h < `VID_HB_LEFT || h >= `VID_HB_RIGHT) begin
            return '0;
        end
        for (layer = 0; layer < `VID_LAYERS; layer++) begin
            w = romWord({videoPkg::layerId_t'(layer), v[7:0], off[8:3]});
            c = w[4*int'(off[2:0]) +: 4];
            if (c != '0) begin
                return {videoPkg::layerId_t'(layer), c};
            end
        end
        return '0;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkHPos(string name, videoPkg::hPos_t got, videoPkg::hPos_t exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkVPos(string name, videoPkg::vPos_t got, videoPkg::vPos_t exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkPixel(videoPkg::pixel_t got, videoPkg::pixel_t exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED at %0t: pixel is %h, expected %h (line %0d)",
                              $time, got, exp, expV));
        end
    endtask

    // one cen tick of the raster rules, all from the old counter values
    task automatic advanceRaster();
        videoPkg::hPos_t h;
        videoPkg::vPos_t v;
        h     = expH;
        v     = expV;
        expHB = h >= `VID_HB_RIGHT || h < `VID_HB_LEFT;  // one tick behind hdump
        if (h == `VID_HSYNC_START) begin
            expHS = 1'b1;
            if (v == `VID_VSYNC_ON) begin
                expVS = 1'b1;
            end else if (v == `VID_VSYNC_OFF) begin
                expVS = 1'b0;
            end
        end else if (h == '0) begin
            expHS = 1'b0;
        end
        if (h == 9'd511) begin
            expVB = expPreVB;  // preVB of the line just ending
            if (v == `VID_LINES - 1) begin
                expV = '0;
                frameCount++;
            end else begin
                expV = v + 9'd1;
            end
        end
        expPreVB = v < `VID_VB_TOP || v > `VID_VB_BOTTOM;
        expH     = h + 9'd1;
        expPix   = (expHB || expVB) ? '0 : refPixel(h, v);
        ticks++;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (rst) begin
                expH     = '0;
                expV     = videoPkg::vPos_t'(`VID_LINES - 1);
                expHS    = 1'b0;
                expVS    = 1'b0;
                expHB    = 1'b1;
                expVB    = 1'b1;
                expPreVB = 1'b0;
                expPix   = '0;
            end else if (cen) begin
                advanceRaster();
            end
        end
    end

    // one cen pulse every four clocks
    initial begin
        cen = 1'b0;
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            #1 cen = 1'b1;
            @(posedge clk);
            #1 cen = 1'b0;
            repeat (2) @(posedge clk);
        end
    end

    // ROM side of the four-phase handshake
    initial begin
        videoPkg::romAddr_t reqAddr;
        seedDummy = $urandom(26);
        romAck  = 1'b0;
        romData = '0;
        forever begin
            do @(negedge clk); while (romReq !== 1'b1);
            reqAddr = romAddr;
            repeat ($urandom_range(4, 1)) @(posedge clk);  // random access time
            #1;
            romData = romWord(reqAddr);
            romAck  = 1'b1;
            do @(negedge clk); while (romReq === 1'b1);
            @(posedge clk);
            #1 romAck = 1'b0;
        end
    end

    // protocol watch on the ROM bus
    initial begin
        logic               prevReq;
        logic               prevAck;
        videoPkg::romAddr_t prevAddr;
        prevReq  = 1'b0;
        prevAck  = 1'b0;
        prevAddr = '0;
        forever begin
            @(negedge clk);
            // romAck only moves just after a rising edge, so prevAck is what the DUT sampled
            if (!rst && romReq && !prevReq && prevAck) begin
                failRun($sformatf("ROM request raised at %0t while romAck was still high", $time));
            end
            if (!rst && romReq && prevReq && romAddr !== prevAddr) begin
                failRun($sformatf("ROM address changed at %0t in the middle of a request", $time));
            end
            prevReq  = romReq === 1'b1;
            prevAck  = romAck === 1'b1;
            prevAddr = romAddr;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                checkHPos("hdump", hdump, expH);
                checkVPos("vdump", vdump, expV);
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                checkBit("HS", HS, expHS);
                checkBit("VS", VS, expVS);
                checkBit("HB", HB, expHB);
                checkBit("VB", VB, expVB);
            end
        end
    end

    // pixels once per tick, second full frame only
    initial begin
        int seenTick;
        seenTick = 0;
        forever begin
            @(negedge clk);
            if (frameCount >= 2 && ticks != seenTick) begin
                seenTick = ticks;
                checkPixel(pixel, expPix);
                if (!expHB && !expVB) begin
                    visibleCount++;
                    if (expPix == '0) begin
                        clearCount++;
                    end else begin
                        layerHits[expPix[5:4]]++;
                    end
                end
            end
        end
    end

    initial begin
        #(limitNs);
        failRun($sformatf("timeout: run still busy after %0d ns", limitNs));
    end

    initial begin
        wait (rst === 1'b0);
        @(negedge clk);
        checkHPos("hdump", hdump, 9'd0);  // straight out of reset
        checkVPos("vdump", vdump, videoPkg::vPos_t'(`VID_LINES - 1));
        checkBit("HB", HB, 1'b1);
        checkBit("VB", VB, 1'b1);
        checkBit("HS", HS, 1'b0);
        checkBit("VS", VS, 1'b0);
        checkBit("romReq", romReq, 1'b0);
        wait (frameCount == 3);
        @(negedge clk);
        @(negedge clk);
        if (visibleCount == visPixels && clearCount > 0 && layerHits[0] > 0
            && layerHits[1] > 0 && layerHits[2] > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            failRun($sformatf("pixel coverage short: %0d visible, %0d clear, hits %0d %0d %0d",
                              visibleCount, clearCount, layerHits[0], layerHits[1],
                              layerHits[2]));
        end
    end

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen #(
    parameter int halfPeriod  = 5,  // 10 ns clock
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;  // released just after the edge like every other input
    end

endmodule

// ==== source/videoTop.sv ====
`timescale 1ns/100ps
`include "video_consts.svh"

module videoTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    output videoPkg::hPos_t    hdump,
    output videoPkg::vPos_t    vdump,
    output logic               HS,
    output logic               VS,
    output logic               HB,
    output logic               VB,
    output videoPkg::pixel_t   pixel,
    output logic               romReq,
    output videoPkg::romAddr_t romAddr,
    input  logic               romAck,
    input  videoPkg::romWord_t romData
);

    videoPkg::vPos_t           vrender;
    logic                      start;
    logic [`VID_LAYERS-1:0]    layerReq;
    logic [`VID_LAYERS-1:0]    layerAck;
    videoPkg::romAddr_t        layerAddr  [`VID_LAYERS];
    videoPkg::romWord_t        layerData;  // shared by all renderers
    videoPkg::colorIdx_t       layerColor [`VID_LAYERS];

    videoTiming uTiming (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .vrender (vrender),
        .start   (start),
        .HS      (HS),
        .VS      (VS),
        .HB      (HB),
        .VB      (VB),
        .preVB   ()
    );

    for (genvar i = 0; i < `VID_LAYERS; i++) begin : gLayer
        layerRenderer #(
            .layerNum (videoPkg::layerId_t'(i))
        ) uLayer (
            .clk     (clk),
            .rst     (rst),
            .cen     (cen),
            .start   (start),
            .vrender (vrender),
            .vdump   (vdump),
            .hdump   (hdump),
            .req     (layerReq[i]),
            .addr    (layerAddr[i]),
            .ack     (layerAck[i]),
            .data    (layerData),
            .color   (layerColor[i])
        );
    end

    romArbiter uArbiter (
        .clk       (clk),
        .rst       (rst),
        .layerReq  (layerReq),
        .layerAddr (layerAddr),
        .layerAck  (layerAck),
        .layerData (layerData),
        .romReq    (romReq),
        .romAddr   (romAddr),
        .romAck    (romAck),
        .romData   (romData)
    );

    colorMixer uMixer (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .HB         (HB),
        .VB         (VB),
        .layerColor (layerColor),
        .pixel      (pixel)
    );

endmodule

// ==== source/colorMixer.sv ====
`timescale 1ns/100ps
`include "video_consts.svh"

module colorMixer (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                HB,
    input  logic                VB,
    input  videoPkg::colorIdx_t layerColor [`VID_LAYERS],
    output videoPkg::pixel_t    pixel
);

    videoPkg::pixel_t nextPix;  // winning layer for the current hdump
    videoPkg::pixel_t pixReg;

    // walk from the bottom layer up so layer 0 wins
    always_comb begin
        nextPix = '0;
        for (int i = `VID_LAYERS - 1; i >= 0; i--) begin
            if (layerColor[i] != '0) begin
                nextPix = {videoPkg::layerId_t'(i), layerColor[i]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pixReg <= '0;
        end else if (cen) begin
            pixReg <= nextPix;  // pixel for the hdump seen at this tick
        end
    end

    // HB and VB are registered on the same tick so they line up with pixReg
    assign pixel = (HB || VB) ? '0 : pixReg;

endmodule

// ==== source/romArbiter.sv ====
`timescale 1ns/100ps
`include "video_consts.svh"

module romArbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`VID_LAYERS-1:0]  layerReq,
    input  videoPkg::romAddr_t      layerAddr [`VID_LAYERS],
    output logic [`VID_LAYERS-1:0]  layerAck,
    output videoPkg::romWord_t      layerData,
    output logic                    romReq,
    output videoPkg::romAddr_t      romAddr,
    input  logic                    romAck,
    input  videoPkg::romWord_t      romData
);

    videoPkg::arbState_t state;
    videoPkg::layerId_t  last;       // layer served most recently
    videoPkg::layerId_t  grant;      // layer in flight
    videoPkg::layerId_t  nextGrant;
    logic                found;

    // round robin search starting after the last served layer
    always_comb begin
        nextGrant = last;
        found     = 1'b0;
        for (int k = 1; k <= `VID_LAYERS; k++) begin
            if (!found && layerReq[(int'(last) + k) % `VID_LAYERS]) begin
                nextGrant = videoPkg::layerId_t'((int'(last) + k) % `VID_LAYERS);
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= videoPkg::ARBIDLE;
            romReq   <= 1'b0;
            layerAck <= '0;
            grant    <= '0;
            last     <= videoPkg::layerId_t'(`VID_LAYERS - 1);  // layer 0 goes first
        end else begin
            case (state)
                videoPkg::ARBIDLE: begin
                    if (found && !romAck) begin  // previous ROM cycle fully closed
                        grant   <= nextGrant;
                        romAddr <= layerAddr[nextGrant];
                        romReq  <= 1'b1;
                        state   <= videoPkg::ROMREQ;
                    end
                end
                videoPkg::ROMREQ: begin
                    if (romAck) begin
                        layerData <= romData;  // held until the layer takes it
                        romReq    <= 1'b0;
                        state     <= videoPkg::ROMDROP;
                    end
                end
                videoPkg::ROMDROP: begin
                    if (!romAck) begin
                        layerAck[grant] <= 1'b1;
                        state           <= videoPkg::LAYERACK;
                    end
                end
                videoPkg::LAYERACK: begin
                    if (!layerReq[grant]) begin
                        layerAck <= '0;
                        state    <= videoPkg::LAYERDROP;
                    end
                end
                videoPkg::LAYERDROP: begin
                    last  <= grant;  // priority rotates past this layer
                    state <= videoPkg::ARBIDLE;
                end
                default: state <= videoPkg::ARBIDLE;
            endcase
        end
    end

    romAddrStable: assert property (@(posedge clk) disable iff (rst)
        romReq |=> (!romReq || $stable(romAddr)))
        else $error("ROM address moved during a request");

    ackOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(layerAck))
        else $error("more than one layer acknowledged");

endmodule

// ==== source/layerRenderer.sv ====
`timescale 1ns/100ps
`include "video_consts.svh"

module layerRenderer #(
    parameter videoPkg::layerId_t layerNum = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                start,
    input  videoPkg::vPos_t     vrender,
    input  videoPkg::vPos_t     vdump,
    input  videoPkg::hPos_t     hdump,
    output logic                req,
    output videoPkg::romAddr_t  addr,
    input  logic                ack,
    input  videoPkg::romWord_t  data,
    output videoPkg::colorIdx_t color
);

    videoPkg::fetchState_t state;
    logic [5:0]            col;      // word column being fetched
    logic                  wrBank;   // bank filled for the next line
    logic [7:0]            lineLo;   // line latched at start
    logic                  wrEn;
    logic [6:0]            wrIdx;
    videoPkg::hPos_t       hVis;     // position inside the visible span
    logic                  visible;
    logic [6:0]            rdIdx;
    videoPkg::romWord_t    rdWord;

    // two banks of one line each
    videoPkg::romWord_t lineBuf [2*`VID_WORDS];

    assign addr = {layerNum, lineLo, col};  // stable for the whole request

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= videoPkg::IDLE;
            req    <= 1'b0;
            col    <= '0;
            wrBank <= 1'b0;
            lineLo <= '0;
        end else begin
            case (state)
                videoPkg::IDLE,
                videoPkg::DONE: begin
                    if (cen && start) begin
                        col    <= '0;
                        wrBank <= vrender[0];     // odd lines use bank 1
                        lineLo <= vrender[7:0];
                        state  <= videoPkg::REQ;
                    end
                end
                videoPkg::REQ: begin
                    req   <= 1'b1;
                    state <= videoPkg::WAITACK;
                end
                videoPkg::WAITACK: begin
                    if (ack) begin
                        req   <= 1'b0;  // word is written this cycle
                        state <= videoPkg::WAITDROP;
                    end
                end
                videoPkg::WAITDROP: begin
                    if (!ack) begin
                        if (col == 6'(`VID_WORDS - 1)) begin
                            state <= videoPkg::DONE;
                        end else begin
                            col   <= col + 6'd1;
                            state <= videoPkg::REQ;
                        end
                    end
                end
                default: state <= videoPkg::IDLE;
            endcase
        end
    end

    assign wrEn  = state == videoPkg::WAITACK && ack;
    assign wrIdx = (wrBank ? 7'(`VID_WORDS) : 7'd0) + {1'b0, col};

    always_ff @(posedge clk) begin
        if (wrEn) begin
            lineBuf[wrIdx] <= data;
        end
    end

    // display side reads the other bank straight from hdump
    assign hVis    = hdump - `VID_HB_LEFT;
    assign visible = hdump >= `VID_HB_LEFT && hdump < `VID_HB_RIGHT;
    assign rdIdx   = (vdump[0] ? 7'(`VID_WORDS) : 7'd0) + {1'b0, hVis[8:3]};
    assign rdWord  = lineBuf[rdIdx];
    assign color   = visible ? rdWord[{hVis[2:0], 2'b00} +: 4] : '0;  // nibble k is pixel k

    // a whole line must be fetched within one line time
    fetchDoneAtStart: assert property (@(posedge clk) disable iff (rst)
        (cen && start) |-> (state == videoPkg::DONE || state == videoPkg::IDLE))
        else $error("layer %0d fetch still busy at line start", layerNum);

endmodule

// ==== source/videoTiming.sv ====
`timescale 1ns/100ps
`include "video_consts.svh"

module videoTiming (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    output videoPkg::hPos_t hdump,
    output videoPkg::vPos_t vdump,
    output videoPkg::vPos_t vrender,
    output logic            start,
    output logic            HS,
    output logic            VS,
    output logic            HB,
    output logic            VB,
    output logic            preVB
);

    videoPkg::vPos_t vrender1;  // two lines ahead of the display

    always_ff @(posedge clk) begin
        if (rst) begin
            hdump    <= '0;
            vdump    <= videoPkg::vPos_t'(`VID_LINES - 1);  // frame starts on the last line
            vrender  <= '0;                                 // one line ahead of vdump
            vrender1 <= 9'd1;
            start    <= 1'b1;  // first line gets fetched straight away
            HS       <= 1'b0;
            VS       <= 1'b0;
            HB       <= 1'b1;
            VB       <= 1'b1;
            preVB    <= 1'b0;
        end else if (cen) begin
            hdump <= hdump + 9'd1;  // 9 bits wrap from 511 to 0 on their own
            preVB <= vdump < `VID_VB_TOP || vdump > `VID_VB_BOTTOM;     // 224 lines shown
            HB    <= hdump >= `VID_HB_RIGHT || hdump < `VID_HB_LEFT;    // lags hdump by a tick

            if (hdump == `VID_HSYNC_START) begin
                HS <= 1'b1;
                // VS only moves on the HS edge so monitors lock cleanly
                if (vdump == `VID_VSYNC_ON) begin
                    VS <= 1'b1;
                end
                if (vdump == `VID_VSYNC_OFF) begin
                    VS <= 1'b0;
                end
            end
            if (hdump == '0) begin
                HS <= 1'b0;  // sync pulse ends at the wrap
            end

            start <= &hdump;  // high while hdump is 0

            if (&hdump) begin
                // line counters advance as a chain
                vrender1 <= (vrender1 == videoPkg::vPos_t'(`VID_LINES - 1)) ? '0
                                                                             : vrender1 + 9'd1;
                vrender  <= vrender1;
                vdump    <= vrender;
                VB       <= preVB;  // vertical blank flips only at line start
            end
        end
    end

endmodule

// ==== source/videoPkg.sv ====
package videoPkg;

    typedef logic [8:0]  hPos_t;      // pixel count within the line
    typedef logic [8:0]  vPos_t;      // line count within the frame
    typedef logic [3:0]  colorIdx_t;  // 0 is transparent
    typedef logic [1:0]  layerId_t;
    typedef logic [5:0]  pixel_t;     // layer above color index
    typedef logic [15:0] romAddr_t;   // layer, line[7:0], column[5:0]
    typedef logic [31:0] romWord_t;   // nibble k is pixel k

    // line fetch sequencing in each renderer
    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAITACK,
        WAITDROP,
        DONE
    } fetchState_t;

    // the arbiter idle state carries its own name so both enums share this scope
    typedef enum logic [2:0] {
        ARBIDLE,
        ROMREQ,
        ROMDROP,
        LAYERACK,
        LAYERDROP
    } arbState_t;

endpackage

// ==== source/video_consts.svh ====
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// raster geometry for the 384x224 arcade screen

`define VID_LAYERS      3       // number of tile layers
`define VID_LINES       262     // lines per frame

// sync positions
`define VID_HSYNC_START 9'h1dc  // HS rises here
`define VID_VSYNC_ON    9'h100  // line that sets VS
`define VID_VSYNC_OFF   9'd1    // line that clears VS

// horizontal blanking edges
`define VID_HB_LEFT     9'd64   // first visible pixel
`define VID_HB_RIGHT    9'd448  // first blanked pixel on the right

// vertical blanking edges
`define VID_VB_TOP      9'd15   // first visible line
`define VID_VB_BOTTOM   9'd238  // last visible line

// each ROM word holds eight pixels so 384/8 words per line
`define VID_WORDS       48

`endif
